/* verilog/icache_pkg.sv */
////////////////////
// shared widths and types of the instruction cache
// imported by every cache module and by the testbench
////////////////////
package icache_pkg;

  ////////////////////
  // widths

  // physical address seen by the fetch unit
  localparam int unsigned PAddrWidth  = 32;
  // one fetched instruction word
  localparam int unsigned FetchWidth  = 32;
  // one cache line, also the refill return width
  localparam int unsigned LineWidth   = 128;
  // byte offset bits inside a line
  localparam int unsigned OffsetWidth = 4;

  ////////////////////
  // memory return port

  // return type, fill data or invalidation
  typedef enum logic {
    ICACHE_IFILL_ACK = 1'b0,
    ICACHE_INV_REQ   = 1'b1
  } icache_rtype_e;

  // invalidation command, padded up to a full line
  typedef struct packed {
    logic                              all;
    logic                              vld;
    logic [PAddrWidth-1:0]             idx;
    logic [LineWidth-PAddrWidth-3:0]   pad;
  } icache_inv_t;

  // same return word, read as a line or as an invalidation
  typedef union packed {
    logic [LineWidth-1:0] data;
    icache_inv_t          inv;
  } icache_rtrn_payload_u;

  typedef struct packed {
    icache_rtype_e        rtype;
    icache_rtrn_payload_u payload;
  } icache_rtrn_t;

  ////////////////////
  // fetch and refill requests

  typedef struct packed {
    logic                  req;
    logic [PAddrWidth-1:0] paddr;
  } icache_fetch_req_t;

  typedef struct packed {
    logic                  valid;
    logic [FetchWidth-1:0] data;
    logic [PAddrWidth-1:0] paddr;
  } icache_fetch_rsp_t;

  // nc requests carry a word address, cacheable ones a line address
  typedef struct packed {
    logic [PAddrWidth-1:0] paddr;
    logic                  nc;
  } icache_mem_req_t;

endpackage

/* verilog/icache_repl.sv */
`timescale 1ns/1ps
////////////////////
// replacement way choice: lowest invalid way, or an LFSR way
// when the set is full, latched the cycle after each lookup
////////////////////
module icache_repl #(
  parameter  int unsigned NumWays  = 4,
  localparam int unsigned WayWidth = $clog2(NumWays)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [NumWays-1:0] valid_i,
  input  logic               capture_i,
  input  logic               advance_i,
  output logic [NumWays-1:0] repl_oh_o
);

  // galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  localparam int unsigned         LfsrWidth = 8;
  localparam logic [LfsrWidth-1:0] LfsrTaps = 8'hB8;
  localparam logic [LfsrWidth-1:0] LfsrSeed = 8'h5A;

  logic [LfsrWidth-1:0] lfsr_d, lfsr_q;
  logic [WayWidth-1:0]  inv_way, rnd_way, sel_way;
  logic                 all_valid;
  logic                 capture_q;
  logic                 full_d, full_q;
  logic [NumWays-1:0]   repl_oh_d, repl_oh_q;

  // lowest way with a clear valid bit
  always_comb begin
    inv_way = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!valid_i[i]) begin
        inv_way = WayWidth'(i);
      end
    end
  end

  assign all_valid = &valid_i;
  assign rnd_way   = lfsr_q[WayWidth-1:0];
  assign sel_way   = all_valid ? rnd_way : inv_way;

  // valid bits of the lookup arrive the cycle after the read
  assign repl_oh_d = capture_q ? (NumWays'(1) << sel_way) : repl_oh_q;
  assign full_d    = capture_q ? all_valid : full_q;

  // step only when a fill replaces a valid line
  assign lfsr_d = (advance_i && full_q) ?
                  ({1'b0, lfsr_q[LfsrWidth-1:1]} ^ (lfsr_q[0] ? LfsrTaps : '0)) : lfsr_q;

  assign repl_oh_o = repl_oh_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q    <= LfsrSeed;
      capture_q <= 1'b0;
      full_q    <= 1'b0;
      repl_oh_q <= '0;
    end else begin
      lfsr_q    <= lfsr_d;
      capture_q <= capture_i;
      full_q    <= full_d;
      repl_oh_q <= repl_oh_d;
    end
  end

endmodule

/* verilog/icache_arrays.sv */
`timescale 1ns/1ps
////////////////////
// per-way tag+valid and data memories with a one-cycle read,
// tag compare and word select from the lowest hitting way
////////////////////
module icache_arrays import icache_pkg::*; #(
  parameter  int unsigned NumWays      = 4,
  parameter  int unsigned NumSets      = 64,
  localparam int unsigned IdxWidth     = $clog2(NumSets),
  localparam int unsigned TagWidth     = PAddrWidth - OffsetWidth - IdxWidth,
  localparam int unsigned WordOffWidth = OffsetWidth - 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    arr_rd_i,
  input  logic                    arr_wr_i,
  input  logic                    vld_we_i,
  input  logic                    vld_wbit_i,
  input  logic [NumWays-1:0]      vld_ways_i,
  input  logic [IdxWidth-1:0]     arr_idx_i,
  input  logic [IdxWidth-1:0]     vld_idx_i,
  input  logic [TagWidth-1:0]     tag_i,
  input  logic [WordOffWidth-1:0] offset_i,
  input  logic [NumWays-1:0]      wr_ways_i,
  input  logic [LineWidth-1:0]    line_i,
  output logic [NumWays-1:0]      hit_o,
  output logic [NumWays-1:0]      valid_o,
  output logic [FetchWidth-1:0]   word_o
);

  // word at the request offset, one per way
  logic [NumWays-1:0][FetchWidth-1:0] way_word;

  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    logic [TagWidth-1:0]  tag_mem  [NumSets];
    logic [LineWidth-1:0] data_mem [NumSets];
    logic [NumSets-1:0]   vld_bits;
    logic [TagWidth-1:0]  tag_q;
    logic [LineWidth-1:0] line_q;
    logic                 vld_q;

    ////////////////////
    // tag + valid

    // tag goes in with the valid bit, only meaningful when set
    always_ff @(posedge clk_i) begin
      if (vld_we_i && vld_ways_i[w]) begin
        tag_mem[vld_idx_i] <= tag_i;
      end
      if (arr_rd_i) begin
        tag_q <= tag_mem[arr_idx_i];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_bits <= '0;
        vld_q    <= 1'b0;
      end else begin
        if (vld_we_i && vld_ways_i[w]) begin
          vld_bits[vld_idx_i] <= vld_wbit_i;
        end
        // read sees the value before a same-cycle write
        if (arr_rd_i) begin
          vld_q <= vld_bits[arr_idx_i];
        end
      end
    end

    ////////////////////
    // data

    always_ff @(posedge clk_i) begin
      if (arr_wr_i && wr_ways_i[w]) begin
        data_mem[arr_idx_i] <= line_i;
      end
      if (arr_rd_i) begin
        line_q <= data_mem[arr_idx_i];
      end
    end

    // compare against the registered request tag
    assign hit_o[w]    = vld_q & (tag_q == tag_i);
    assign valid_o[w]  = vld_q;
    assign way_word[w] = line_q[offset_i*FetchWidth +: FetchWidth];
  end

  // lowest hitting way wins, should be one-hot anyway
  always_comb begin
    word_o = way_word[0];
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit_o[i]) begin
        word_o = way_word[i];
      end
    end
  end

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps
////////////////////
// instruction cache controller: fetch FSM, refill requests,
// flush sequencing and valid-bit addressing of the arrays
////////////////////
module icache_ctrl import icache_pkg::*; #(
  parameter  int unsigned NumWays      = 4,
  parameter  int unsigned NumSets      = 64,
  localparam int unsigned IdxWidth     = $clog2(NumSets),
  localparam int unsigned TagWidth     = PAddrWidth - OffsetWidth - IdxWidth,
  localparam int unsigned WordOffWidth = OffsetWidth - 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    en_i,
  input  icache_fetch_req_t       fetch_req_i,
  output logic                    ready_o,
  output icache_fetch_rsp_t       fetch_rsp_o,
  output logic                    miss_o,
  output logic                    mem_req_o,
  output icache_mem_req_t         mem_req_data_o,
  input  logic                    mem_ack_i,
  input  logic                    mem_rtrn_vld_i,
  input  icache_rtrn_t            mem_rtrn_i,
  input  logic [NumWays-1:0]      hit_i,
  input  logic [FetchWidth-1:0]   hit_word_i,
  output logic                    arr_rd_o,
  output logic                    arr_wr_o,
  output logic                    vld_we_o,
  output logic                    vld_wbit_o,
  output logic [NumWays-1:0]      vld_ways_o,
  output logic [IdxWidth-1:0]     arr_idx_o,
  output logic [IdxWidth-1:0]     vld_idx_o,
  output logic [TagWidth-1:0]     tag_o,
  output logic [WordOffWidth-1:0] offset_o,
  input  logic [NumWays-1:0]      repl_oh_i
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e                state_d, state_q;
  logic [PAddrWidth-1:0] paddr_q;
  logic                  nc_d, nc_q;
  logic                  en_d, en_q;
  logic                  flush_d, flush_q;
  logic                  inv_q;
  logic                  mreq_q;
  logic [IdxWidth-1:0]   flush_cnt_d, flush_cnt_q;
  logic                  flush_en, flush_done;
  logic                  inv_en, inv_all, fill_en;
  logic                  flush_req, flush_pend;
  logic                  accept, hit_ok, rsp_valid;
  logic [FetchWidth-1:0] rtrn_word;
  icache_inv_t           inv;

  ////////////////////
  // return port decode

  assign inv       = mem_rtrn_i.payload.inv;
  assign inv_en    = mem_rtrn_vld_i & (mem_rtrn_i.rtype == ICACHE_INV_REQ);
  assign fill_en   = mem_rtrn_vld_i & (mem_rtrn_i.rtype == ICACHE_IFILL_ACK);
  // invalidate-all is handled by a full flush
  assign inv_all   = inv_en & inv.all;
  assign rtrn_word = mem_rtrn_i.payload.data[offset_o*FetchWidth +: FetchWidth];

  // pending flush, or the cache being switched back on
  assign flush_req  = flush_q | flush_i | inv_all;
  assign flush_pend = flush_req | (en_i & ~en_q);

  // only a cacheable lookup may hit
  assign hit_ok = (|hit_i) & ~nc_q;
  assign accept = ready_o & fetch_req_i.req;

  ////////////////////
  // main FSM

  always_comb begin
    state_d   = state_q;
    // disabling is immediate, enabling goes through a flush
    en_d      = en_q & en_i;
    flush_d   = flush_req;
    flush_en  = 1'b0;
    arr_rd_o  = 1'b0;
    arr_wr_o  = 1'b0;
    ready_o   = 1'b0;
    rsp_valid = 1'b0;
    mem_req_o = 1'b0;
    miss_o    = 1'b0;
    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d = IDLE;
          flush_d = flush_i | inv_all;
          en_d    = en_i;
        end
      end
      IDLE: begin
        if (flush_pend) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_vld_i) begin
          ready_o = 1'b1;
          if (fetch_req_i.req) begin
            arr_rd_o = 1'b1;
            state_d  = READ;
          end
        end
      end
      // tag compare, nc and disabled accesses reuse the miss path
      READ: begin
        if (mreq_q) begin
          // request already raised, hold it until acked
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end else if (inv_en || inv_q) begin
          // valid bits changed under the lookup, read again
          arr_rd_o = 1'b1;
        end else if (hit_ok) begin
          rsp_valid = 1'b1;
          state_d   = IDLE;
          if (flush_pend) begin
            state_d = FLUSH;
          end else if (!mem_rtrn_vld_i) begin
            ready_o = 1'b1;
            if (fetch_req_i.req) begin
              arr_rd_o = 1'b1;
              state_d  = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // wait for the line, nc data is only forwarded
      MISS: begin
        if (fill_en) begin
          rsp_valid = 1'b1;
          arr_wr_o  = ~nc_q;
          state_d   = flush_pend ? FLUSH : IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////
  // flush counter and valid-bit addressing

  assign flush_done  = (flush_cnt_q == IdxWidth'(NumSets - 1));
  assign flush_cnt_d = flush_done ? '0 : flush_en ? flush_cnt_q + 1'b1 : flush_cnt_q;

  // flush before invalidation before lookup index
  assign vld_we_o   = flush_en | inv_en | arr_wr_o;
  assign vld_wbit_o = arr_wr_o;
  assign vld_idx_o  = flush_en ? flush_cnt_q :
                      inv_en   ? inv.idx[OffsetWidth +: IdxWidth] :
                                 paddr_q[OffsetWidth +: IdxWidth];
  assign vld_ways_o = flush_en ? '1 :
                      inv_en   ? {NumWays{inv.all | inv.vld}} :
                                 repl_oh_i;

  // new request index goes straight to the arrays
  assign arr_idx_o = accept ? fetch_req_i.paddr[OffsetWidth +: IdxWidth] :
                              paddr_q[OffsetWidth +: IdxWidth];
  assign tag_o     = paddr_q[PAddrWidth-1 -: TagWidth];
  assign offset_o  = paddr_q[2 +: WordOffWidth];

  // top address bit or a disabled cache means nc
  assign nc_d = accept ? (~en_q | fetch_req_i.paddr[PAddrWidth-1]) : nc_q;

  ////////////////////
  // interface outputs

  assign fetch_rsp_o.valid    = rsp_valid;
  assign fetch_rsp_o.data     = (state_q == MISS) ? rtrn_word : hit_word_i;
  assign fetch_rsp_o.paddr    = paddr_q;
  assign mem_req_data_o.nc    = nc_q;
  assign mem_req_data_o.paddr = nc_q ? {paddr_q[PAddrWidth-1:2], 2'b00} :
                                       {paddr_q[PAddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      nc_q        <= 1'b0;
      en_q        <= 1'b0;
      flush_q     <= 1'b0;
      inv_q       <= 1'b0;
      mreq_q      <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      nc_q        <= nc_d;
      en_q        <= en_d;
      flush_q     <= flush_d;
      inv_q       <= inv_en;
      mreq_q      <= mem_req_o & ~mem_ack_i;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // request address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q <= fetch_req_i.paddr;
    end
  end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps
////////////////////
// set-associative instruction cache top, fetch port in,
// line refill port out; sets the geometry for all submodules
////////////////////
module icache_top import icache_pkg::*; #(
  parameter  int unsigned NumWays      = 4,
  parameter  int unsigned NumSets      = 64,
  localparam int unsigned IdxWidth     = $clog2(NumSets),
  localparam int unsigned TagWidth     = PAddrWidth - OffsetWidth - IdxWidth,
  localparam int unsigned WordOffWidth = OffsetWidth - 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              en_i,
  input  icache_fetch_req_t fetch_req_i,
  output logic              ready_o,
  output icache_fetch_rsp_t fetch_rsp_o,
  output logic              miss_o,
  output logic              mem_req_o,
  output icache_mem_req_t   mem_req_data_o,
  input  logic              mem_ack_i,
  input  logic              mem_rtrn_vld_i,
  input  icache_rtrn_t      mem_rtrn_i
);

  // array control from the FSM
  logic                    arr_rd, arr_wr;
  logic                    vld_we, vld_wbit;
  logic [NumWays-1:0]      vld_ways;
  logic [IdxWidth-1:0]     arr_idx, vld_idx;
  logic [TagWidth-1:0]     tag;
  logic [WordOffWidth-1:0] offset;
  // lookup results back to the FSM
  logic [NumWays-1:0]      hit, valid, repl_oh;
  logic [FetchWidth-1:0]   hit_word;

  icache_ctrl #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) i_ctrl (
    .clk_i, .rst_ni, .flush_i, .en_i, .fetch_req_i, .ready_o, .fetch_rsp_o, .miss_o,
    .mem_req_o, .mem_req_data_o, .mem_ack_i, .mem_rtrn_vld_i, .mem_rtrn_i,
    .hit_i      ( hit      ),
    .hit_word_i ( hit_word ),
    .arr_rd_o   ( arr_rd   ),
    .arr_wr_o   ( arr_wr   ),
    .vld_we_o   ( vld_we   ),
    .vld_wbit_o ( vld_wbit ),
    .vld_ways_o ( vld_ways ),
    .arr_idx_o  ( arr_idx  ),
    .vld_idx_o  ( vld_idx  ),
    .tag_o      ( tag      ),
    .offset_o   ( offset   ),
    .repl_oh_i  ( repl_oh  )
  );

  // choice latched after each lookup, lfsr steps on fills
  icache_repl #(
    .NumWays ( NumWays )
  ) i_repl (
    .clk_i, .rst_ni,
    .valid_i   ( valid   ),
    .capture_i ( arr_rd  ),
    .advance_i ( arr_wr  ),
    .repl_oh_o ( repl_oh )
  );

  icache_arrays #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) i_arrays (
    .clk_i, .rst_ni,
    .arr_rd_i   ( arr_rd   ), .arr_wr_i   ( arr_wr   ),
    .vld_we_i   ( vld_we   ), .vld_wbit_i ( vld_wbit ),
    .vld_ways_i ( vld_ways ), .arr_idx_i  ( arr_idx  ),
    .vld_idx_i  ( vld_idx  ), .tag_i      ( tag      ),
    .offset_i   ( offset   ), .wr_ways_i  ( repl_oh  ),
    .line_i     ( mem_rtrn_i.payload.data ),
    .hit_o      ( hit      ),
    .valid_o    ( valid    ),
    .word_o     ( hit_word )
  );

endmodule

/* testbench/icache_props.sv */
`timescale 1ns/1ps
////////////////////
// controller properties, bound into the cache FSM
////////////////////
module icache_props import icache_pkg::*; (
  input logic            clk_i,
  input logic            rst_ni,
  input logic [1:0]      state_i,
  input logic            rsp_valid_i,
  input logic            mem_req_i,
  input logic            mem_ack_i,
  input icache_mem_req_t mem_req_data_i,
  input logic            arr_wr_i,
  input logic            inv_en_i
);

  // first state of the FSM encoding
  localparam logic [1:0] FlushState = 2'd0;

  // no fetch response while the valid bits are being cleared
  valid_not_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> (state_i != FlushState))
    else $error("fetch response valid in a flush cycle");

  // refill request stays up and stable until acked
  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> (mem_req_i && $stable(mem_req_data_i)))
    else $error("refill request dropped or changed before its ack");

  fill_not_with_inval: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arr_wr_i |-> !inv_en_i)
    else $error("fill write in the same cycle as an invalidation");

endmodule

bind icache_ctrl icache_props i_icache_props (
  .clk_i          ( clk_i             ),
  .rst_ni         ( rst_ni            ),
  .state_i        ( state_q           ),
  .rsp_valid_i    ( fetch_rsp_o.valid ),
  .mem_req_i      ( mem_req_o         ),
  .mem_ack_i      ( mem_ack_i         ),
  .mem_req_data_i ( mem_req_data_o    ),
  .arr_wr_i       ( arr_wr_o          ),
  .inv_en_i       ( inv_en            )
);

/* testbench/tb_icache.sv */
`timescale 1ns/1ps
////////////////////
// instruction cache testbench with a memory responder, random and
// directed fetches, checked against a line rule and a residency model
////////////////////
module tb_icache import icache_pkg::*; ();

  localparam int unsigned NumWays   = 4;
  localparam int unsigned NumSets   = 16;
  localparam int unsigned Timeout   = 200;
  localparam int unsigned NumRandom = 40;

  logic              clk_i;
  logic              rst_ni;
  logic              flush_i;
  logic              en_i;
  icache_fetch_req_t fetch_req_i;
  logic              ready_o;
  icache_fetch_rsp_t fetch_rsp_o;
  logic              miss_o;
  logic              mem_req_o;
  icache_mem_req_t   mem_req_data_o;
  logic              mem_ack_i;
  logic              mem_rtrn_vld_i;
  icache_rtrn_t      mem_rtrn_i;

  // model state with accepted addresses in order and lines filled since last removal
  logic [31:0] addr_q [$];
  bit          filled [logic [31:0]];
  int unsigned n_checks;
  int unsigned n_errors;
  bit          aborted;
  // invalidation handed to the responder
  bit          inv_pend;
  bit          inv_all_req;
  logic [31:0] inv_addr;

  icache_top #(
    .NumWays ( NumWays ),
    .NumSets ( NumSets )
  ) icache_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // line rule and helpers

  // every word of memory is its own byte address bit-reversed
  function automatic logic [31:0] reverse_bits(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  function automatic logic [31:0] line_addr(input logic [31:0] a);
    return {a[31:4], 4'h0};
  endfunction

  function automatic int unsigned set_of(input logic [31:0] a);
    return (a >> 4) % NumSets;
  endfunction

  // word w of the line sits at bits [32w+31:32w]
  function automatic logic [LineWidth-1:0] line_for(input logic [31:0] a);
    logic [LineWidth-1:0] line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = reverse_bits(line_addr(a) + 32'(w * 4));
    end
    return line;
  endfunction

  // a set invalidation removes every line at that index
  function automatic void drop_set(input logic [31:0] a);
    logic [31:0] keys [$];
    foreach (filled[k]) begin
      if (set_of(k) == set_of(a)) begin
        keys.push_back(k);
      end
    end
    foreach (keys[i]) begin
      filled.delete(keys[i]);
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (aborted) return;
    n_checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    if (aborted) return;
    n_checks++;
    assert (cond) else begin
      $display("error at %0t: %s", $time, what);
      n_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: no %s within %0d cycles", $time, what, Timeout);
    n_errors++;
    aborted = 1'b1;
  endtask

  ////////////////////
  // memory responder

  // ack after 0..3 extra cycles and line 1..5 cycles after the ack
  initial begin : mem_responder
    icache_mem_req_t req;
    icache_rtrn_t    rtrn;
    int unsigned     ack_dly;
    int unsigned     fill_dly;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    forever begin
      @(negedge clk_i);
      if (inv_pend) begin
        rtrn                 = '0;
        rtrn.rtype           = ICACHE_INV_REQ;
        rtrn.payload.inv.all = inv_all_req;
        rtrn.payload.inv.vld = ~inv_all_req;
        rtrn.payload.inv.idx = inv_addr;
        @(posedge clk_i);
        mem_rtrn_i     <= rtrn;
        mem_rtrn_vld_i <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i <= 1'b0;
        inv_pend = 1'b0;
      end else if (rst_ni && mem_req_o) begin
        req      = mem_req_data_o;
        ack_dly  = $urandom_range(3, 0);
        fill_dly = $urandom_range(5, 1);
        repeat (ack_dly) @(posedge clk_i);
        @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        repeat (fill_dly - 1) @(posedge clk_i);
        rtrn              = '0;
        rtrn.rtype        = ICACHE_IFILL_ACK;
        rtrn.payload.data = line_for(req.paddr);
        mem_rtrn_i     <= rtrn;
        mem_rtrn_vld_i <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i <= 1'b0;
      end
    end
  end

  task automatic send_inval(input bit all, input logic [31:0] addr);
    int unsigned wait_cnt;
    if (aborted) return;
    inv_all_req = all;
    inv_addr    = addr;
    inv_pend    = 1'b1;
    wait_cnt    = 0;
    while (inv_pend) begin
      @(negedge clk_i);
      if (++wait_cnt > Timeout) begin
        report_timeout("invalidation sent");
        return;
      end
    end
  endtask

  ////////////////////
  // one fetch from request to response

  task automatic fetch_word(input logic [31:0] addr, output int unsigned n_req);
    int unsigned wait_cnt;
    int unsigned n_miss;
    bit          nc;
    bit          done;
    logic [31:0] exp_addr;
    n_req  = 0;
    n_miss = 0;
    if (aborted) return;
    @(posedge clk_i);
    nc = addr[31] | ~en_i;
    fetch_req_i <= '{req: 1'b1, paddr: addr};
    wait_cnt = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (ready_o) begin
        done = 1'b1;
      end else if (++wait_cnt > Timeout) begin
        report_timeout("ready_o");
        return;
      end
    end
    addr_q.push_back(addr);
    @(posedge clk_i);
    fetch_req_i <= '0;
    wait_cnt = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      // request word and miss pulse in the ack cycle
      if (mem_req_o && mem_ack_i) begin
        n_req++;
        check_value("mem_req_data_o.nc", 32'(mem_req_data_o.nc), 32'(nc));
        check_value("mem_req_data_o.paddr", mem_req_data_o.paddr,
                    nc ? addr : line_addr(addr));
        check_value("miss_o", 32'(miss_o), 32'(!nc));
      end
      if (miss_o) begin
        n_miss++;
      end
      if (fetch_rsp_o.valid) begin
        done     = 1'b1;
        exp_addr = addr_q.pop_front();
        check_value("fetch_rsp_o.paddr", fetch_rsp_o.paddr, exp_addr);
        check_value("fetch_rsp_o.data", fetch_rsp_o.data, reverse_bits(exp_addr));
      end else if (++wait_cnt > Timeout) begin
        report_timeout("fetch response");
        return;
      end
    end
    // residency model
    if (nc) begin
      check_true(n_req == 1, "non-cacheable access did not request memory once");
    end else if (!filled.exists(line_addr(addr))) begin
      check_true(n_req == 1, "access to an absent line did not request memory");
    end
    check_value("miss_o pulse count", n_miss, nc ? 0 : n_req);
    if (!nc && n_req == 1) begin
      filled[line_addr(addr)] = 1'b1;
    end
  endtask

  ////////////////////
  // directed tests

  task automatic reset_and_random_reads();
    int unsigned low_cycles;
    int unsigned n_req;
    int unsigned errs;
    bit          up;
    errs       = n_errors;
    low_cycles = 0;
    up         = 1'b0;
    while (!up && !aborted) begin
      @(negedge clk_i);
      check_true(!(fetch_rsp_o.valid || mem_req_o || miss_o),
                 "fetch valid, mem_req_o or miss_o high during the reset flush");
      if (ready_o) begin
        up = 1'b1;
      end else if (++low_cycles > Timeout) begin
        report_timeout("ready_o after reset");
      end
    end
    check_value("ready_o low cycles", low_cycles, NumSets);
    // small address range so that some lines get reused
    for (int i = 0; i < NumRandom; i++) begin
      fetch_word($urandom & 32'h0000_3ffc, n_req);
    end
    $display("test 1, reset flush and random reads: %0d errors", n_errors - errs);
  endtask

  task automatic back_to_back_hits();
    int unsigned n_req;
    int unsigned errs;
    logic [31:0] base;
    errs = n_errors;
    for (int i = 0; i < 4; i++) begin
      base = 32'h0001_0000 + 32'(i) * 32'h110;
      fetch_word(base | ($urandom & 32'hc), n_req);
      check_value("first access requests", n_req, 1);
      fetch_word(base | ($urandom & 32'hc), n_req);
      check_value("second access requests", n_req, 0);
    end
    $display("test 2, back-to-back line reuse: %0d errors", n_errors - errs);
  endtask

  task automatic noncacheable_reads();
    int unsigned n_req;
    int unsigned errs;
    logic [31:0] addr;
    errs = n_errors;
    for (int i = 0; i < 4; i++) begin
      addr = 32'h8000_0000 | ($urandom & 32'h0000_3ffc);
      fetch_word(addr, n_req);
      fetch_word(addr, n_req);
    end
    // resident line from test 2 read with the cache off
    addr = 32'h0001_0004;
    fetch_word(addr, n_req);
    check_value("resident line requests", n_req, 0);
    @(posedge clk_i);
    en_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    fetch_word(addr, n_req);
    fetch_word(addr, n_req);
    // enabling again clears every line
    @(posedge clk_i);
    en_i <= 1'b1;
    filled.delete();
    fetch_word(addr, n_req);
    check_value("access after enable requests", n_req, 1);
    $display("test 3, non-cacheable and disabled reads: %0d errors", n_errors - errs);
  endtask

  task automatic flush_and_inval_all();
    int unsigned n_req;
    int unsigned errs;
    logic [31:0] addr;
    errs = n_errors;
    addr = 32'h0002_0048;
    fetch_word(addr, n_req);
    fetch_word(addr, n_req);
    check_value("hit before flush requests", n_req, 0);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    filled.delete();
    fetch_word(addr, n_req);
    check_value("access after flush requests", n_req, 1);
    fetch_word(addr, n_req);
    check_value("hit before invalidate-all requests", n_req, 0);
    send_inval(1'b1, '0);
    filled.delete();
    fetch_word(addr, n_req);
    check_value("access after invalidate-all requests", n_req, 1);
    $display("test 4, flush and invalidate-all: %0d errors", n_errors - errs);
  endtask

  task automatic set_invalidation();
    int unsigned n_req;
    int unsigned errs;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    errs   = n_errors;
    // index 3 and index 5
    addr_a = 32'h0003_0034;
    addr_b = 32'h0003_0058;
    fetch_word(addr_a, n_req);
    fetch_word(addr_b, n_req);
    fetch_word(addr_a, n_req);
    check_value("line a before invalidation requests", n_req, 0);
    fetch_word(addr_b, n_req);
    check_value("line b before invalidation requests", n_req, 0);
    send_inval(1'b0, addr_a);
    drop_set(addr_a);
    fetch_word(addr_a, n_req);
    check_value("invalidated line a requests", n_req, 1);
    fetch_word(addr_b, n_req);
    check_value("untouched line b requests", n_req, 0);
    $display("test 5, set invalidation: %0d errors", n_errors - errs);
  endtask

  initial begin : main_seq
    void'($urandom(6104));
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    en_i        = 1'b1;
    fetch_req_i = '0;
    n_checks    = 0;
    n_errors    = 0;
    aborted     = 1'b0;
    inv_pend    = 1'b0;
    inv_all_req = 1'b0;
    inv_addr    = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_and_random_reads();
    back_to_back_hits();
    noncacheable_reads();
    flush_and_inval_all();
    set_invalidation();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
verilog/icache_pkg.sv
verilog/icache_repl.sv
verilog/icache_arrays.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/icache_props.sv
testbench/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_repl.sv
  - verilog/icache_arrays.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: test
    files:
      - testbench/icache_props.sv
      - testbench/tb_icache.sv
